// ==== lmh6401_gain.f ====
hw/daq_cfg_pkg.sv
hw/lmh6401_pkg.sv
hw/gain_wb_regs.sv
hw/spi_frame_seq.sv
hw/spi_shift_sel.sv
hw/lmh6401_gain_top.sv
sim/lmh6401_gain_props.sv
sim/lmh6401_spi_monitor.sv
sim/tb_lmh6401_gain.sv

// ==== Bender.yml ====
package:
  name: lmh6401_gain

sources:
  - hw/daq_cfg_pkg.sv
  - hw/lmh6401_pkg.sv
  - hw/gain_wb_regs.sv
  - hw/spi_frame_seq.sv
  - hw/spi_shift_sel.sv
  - hw/lmh6401_gain_top.sv
  - target: simulation
    files:
      - sim/lmh6401_gain_props.sv
      - sim/lmh6401_spi_monitor.sv
      - sim/tb_lmh6401_gain.sv

// ==== sim/tb_lmh6401_gain.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the LMH6401 gain path, SCK_HALF set to 4
// frame checks live in the SPI monitor, assertions are bound in
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_lmh6401_gain;
  import daq_cfg_pkg::*;
  import lmh6401_pkg::*;

  localparam int SCK_HALF = 4;
  localparam int CLK_FREQ = 50_000_000;
  localparam int SPI_FREQ = CLK_FREQ / (2 * SCK_HALF);
  localparam int CHANNELS = CHANNELS_DEFAULT;
  localparam int FRAME_CYCLES = 33 * SCK_HALF + 1;
  localparam int ACK_LIMIT = FRAME_CYCLES + 20;

  typedef struct packed {
    logic [CHANNELS-1:0]   cs_n;
    logic [LMH_WORD_W-1:0] seq;
  } frame_t;

  logic      ps_clk;
  logic      rst;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  spi_pins_t spi;
  logic      timed_out;
  int        sent_frames;

  lmh6401_gain_top #(
    .CHANNELS(CHANNELS),
    .CLK_FREQ(CLK_FREQ),
    .SPI_FREQ(SPI_FREQ)
  ) lmh6401_gain_top_i (
    .ps_clk,
    .rst,
    .wb_req,
    .wb_rsp,
    .spi
  );

  lmh6401_spi_monitor #(
    .SCK_HALF(SCK_HALF)
  ) spi_monitor_i (
    .ps_clk,
    .rst,
    .spi
  );

  always #10 ps_clk = ~ps_clk;

  // one-hot active-low select, word sent MSB first
  function automatic frame_t ref_frame(input int ch, input logic [LMH_WORD_W-1:0] word);
    frame_t f;
    f.cs_n = '1;
    if (ch < CHANNELS) begin
      f.cs_n[ch] = 1'b0;
    end
    for (int k = 0; k < LMH_WORD_W; k++) begin
      f.seq[k] = word[LMH_WORD_W-1-k];
    end
    return f;
  endfunction

  function automatic logic [WB_DATA_W-1:0] status_word(input int count, input logic refused,
                                                       input logic busy);
    return {count[15:0], 14'b0, refused, busy};
  endfunction

  task automatic wb_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                          input logic [WB_DATA_W-1:0] wdata, output logic [WB_DATA_W-1:0] rdata);
    int   n;
    logic got_ack;
    rdata = '0;
    if (timed_out) begin
      return;
    end
    @(posedge ps_clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
    n = 0;
    got_ack = 1'b0;
    while (!got_ack && n < ACK_LIMIT) begin
      @(negedge ps_clk);
      got_ack = wb_rsp.ack;
      n++;
    end
    if (got_ack) begin
      rdata = wb_rsp.dat_r;
    end else begin
      timed_out = 1'b1;
      $display("timeout: no Wishbone ack at address 0x%0h", adr);
    end
    @(posedge ps_clk);
    wb_req <= '0;
  endtask

  task automatic send_gain(input int ch, input logic [LMH_WORD_W-1:0] word);
    frame_t               f;
    spi_cmd_t             c;
    logic [WB_DATA_W-1:0] rd;
    f = ref_frame(ch, word);
    c.ch = CH_BITS_MAX'(ch);
    c.word.raw = word;
    spi_monitor_i.push_expected(f.cs_n, f.seq);
    wb_cycle(1'b1, REG_CMD, WB_DATA_W'(c), rd);
    sent_frames++;
  endtask

  task automatic wait_frames(input int target, input int limit);
    int n;
    if (timed_out) begin
      return;
    end
    n = 0;
    while (spi_monitor_i.frames_done < target && n < limit) begin
      @(negedge ps_clk);
      n++;
    end
    if (spi_monitor_i.frames_done < target) begin
      timed_out = 1'b1;
      $display("timeout: SPI frame %0d never finished", target);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (spi_monitor_i.errors == errs_before && !timed_out) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////
  initial begin
    logic [WB_DATA_W-1:0] rd;
    logic [CHANNELS-1:0]  cs_all;
    spi_cmd_t             c;
    int                   errs;
    int                   base;
    int                   total_errs;
    ps_clk = 1'b0;
    rst = 1'b1;
    wb_req = '0;
    timed_out = 1'b0;
    sent_frames = 0;
    void'($urandom(32'h854607cb));
    repeat (16) @(posedge ps_clk);
    rst <= 1'b0;
    repeat (2) @(posedge ps_clk);

    errs = spi_monitor_i.errors;
    @(negedge ps_clk);
    spi_monitor_i.compare("cs_n", spi.cs_n, {CHANNELS{1'b1}});
    spi_monitor_i.compare("sck", spi.sck, 0);
    wb_cycle(1'b0, REG_STATUS, '0, rd);
    spi_monitor_i.compare("status", rd, 0);
    end_test("reset state", errs);

    errs = spi_monitor_i.errors;
    send_gain(5, 16'h0234);
    wait_frames(sent_frames, ACK_LIMIT);
    wb_cycle(1'b0, REG_STATUS, '0, rd);
    spi_monitor_i.compare("status", rd, status_word(sent_frames, 1'b0, 1'b0));
    end_test("single write", errs);

    // second ack must wait for the first frame to end
    errs = spi_monitor_i.errors;
    base = spi_monitor_i.frames_done;
    send_gain(1, 16'h0211);
    send_gain(6, 16'h0245);
    spi_monitor_i.compare("frames_done", spi_monitor_i.frames_done, base + 1);
    wait_frames(sent_frames, ACK_LIMIT);
    end_test("back-to-back", errs);

    errs = spi_monitor_i.errors;
    c.ch = 3'd2;
    c.word.f.rw = 1'b1;
    c.word.f.reg_addr = 7'h02;
    c.word.f.reg_data = 8'h0a;
    wb_cycle(1'b1, REG_CMD, WB_DATA_W'(c), rd);
    cs_all = '1;
    for (int i = 0; i < 40 * SCK_HALF; i++) begin
      @(negedge ps_clk);
      cs_all = cs_all & spi.cs_n;
    end
    spi_monitor_i.compare("cs_n", cs_all, {CHANNELS{1'b1}});
    wb_cycle(1'b0, REG_STATUS, '0, rd);
    spi_monitor_i.compare("status", rd, status_word(sent_frames, 1'b1, 1'b0));
    wb_cycle(1'b1, REG_STATUS, 32'h2, rd);
    wb_cycle(1'b0, REG_STATUS, '0, rd);
    spi_monitor_i.compare("status", rd, status_word(sent_frames, 1'b0, 1'b0));
    end_test("read refused", errs);

    errs = spi_monitor_i.errors;
    for (int i = 0; i < 20; i++) begin
      send_gain($urandom % CHANNELS, {1'b0, 15'($urandom)});
    end
    wait_frames(sent_frames, ACK_LIMIT);
    wb_cycle(1'b0, REG_STATUS, '0, rd);
    spi_monitor_i.compare("status", rd, status_word(sent_frames, 1'b0, 1'b0));
    end_test("random writes", errs);

    if (!timed_out) begin
      spi_monitor_i.report_missing();
    end
    total_errs = spi_monitor_i.errors + lmh6401_gain_top_i.lmh6401_gain_props_i.fails;
    $display("checks %0d, errors %0d, timeouts %0d", spi_monitor_i.checks, total_errs,
             timed_out);
    if (total_errs == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim/lmh6401_spi_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// SPI frame checker, samples pins on the falling ps_clk edge
// expected frames are queued in transmission order (bit k sent k-th)
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lmh6401_spi_monitor #(
  parameter int SCK_HALF = 4
) (
  input logic                   ps_clk,
  input logic                   rst,
  input lmh6401_pkg::spi_pins_t spi
);
  import daq_cfg_pkg::*;
  import lmh6401_pkg::*;

  localparam int CS_W = CHANNELS_DEFAULT;

  logic [CS_W-1:0]       exp_cs_q[$];
  logic [LMH_WORD_W-1:0] exp_seq_q[$];
  int                    errors = 0;
  int                    checks = 0;
  int                    frames_done = 0;
  logic                  in_frame;
  logic                  prev_sck;
  logic [CS_W-1:0]       frame_cs;
  logic [LMH_WORD_W-1:0] rx_seq;
  int                    rises;
  int                    low_cycles;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic push_expected(input logic [CS_W-1:0] cs_n, input logic [LMH_WORD_W-1:0] seq);
    exp_cs_q.push_back(cs_n);
    exp_seq_q.push_back(seq);
  endtask

  task automatic report_missing();
    if (exp_seq_q.size() != 0) begin
      errors++;
      $display("%0d expected SPI frames never appeared", exp_seq_q.size());
    end
  endtask

  task automatic check_frame();
    logic [CS_W-1:0]       cs_e;
    logic [LMH_WORD_W-1:0] seq_e;
    if (exp_seq_q.size() == 0) begin
      errors++;
      $display("frame on cs_n 0x%0h arrived with nothing expected", frame_cs);
    end else begin
      cs_e = exp_cs_q.pop_front();
      seq_e = exp_seq_q.pop_front();
      compare("cs_n", frame_cs, cs_e);
      compare("sdi", rx_seq, seq_e);
      compare("sck rising edges", rises, LMH_WORD_W);
      compare("cs_n low cycles", low_cycles, 33 * SCK_HALF);
    end
    frames_done++;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // frame capture
  //////////////////////////////////////////////////////////////////////////
  always @(negedge ps_clk) begin
    if (rst) begin
      in_frame = 1'b0;
      prev_sck = 1'b0;
    end else begin
      if (!in_frame && !(&spi.cs_n)) begin
        in_frame = 1'b1;
        frame_cs = spi.cs_n;
        rx_seq = '0;
        rises = 0;
        low_cycles = 0;
      end
      if (in_frame && (&spi.cs_n)) begin
        check_frame();
        in_frame = 1'b0;
      end else if (in_frame) begin
        low_cycles++;
        if (spi.cs_n !== frame_cs) begin
          compare("cs_n", spi.cs_n, frame_cs);
        end
        // device samples sdi on the rising sck edge
        if (spi.sck && !prev_sck) begin
          if (rises < LMH_WORD_W) begin
            rx_seq[rises] = spi.sdi;
          end
          rises++;
        end
      end
      prev_sck = spi.sck;
    end
  end

endmodule

// ==== sim/lmh6401_gain_props.sv ====
////////////////////////////////////////////////////////////////////////////
// bus and pin properties, bound into lmh6401_gain_top
// fails counts assertion failures for the testbench summary
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lmh6401_gain_props (
  input logic                   ps_clk,
  input logic                   rst,
  input daq_cfg_pkg::wb_req_t   wb_req,
  input daq_cfg_pkg::wb_rsp_t   wb_rsp,
  input lmh6401_pkg::spi_pins_t spi
);
  int fails = 0;

  // shared bus, one device at a time
  one_select: assert property (@(posedge ps_clk) disable iff (rst)
    $countones(~spi.cs_n) <= 1) else begin
    fails++;
    $error("more than one cs_n low: %0h", spi.cs_n);
  end

  sck_idle_low: assert property (@(posedge ps_clk) disable iff (rst)
    (&spi.cs_n) |-> !spi.sck) else begin
    fails++;
    $error("sck high with no device selected");
  end

  ack_in_cycle: assert property (@(posedge ps_clk) disable iff (rst)
    $rose(wb_rsp.ack) |-> (wb_req.cyc && wb_req.stb)) else begin
    fails++;
    $error("ack raised outside a Wishbone cycle");
  end

endmodule

bind lmh6401_gain_top lmh6401_gain_props lmh6401_gain_props_i (.*);

// ==== hw/lmh6401_gain_top.sv ====
////////////////////////////////////////////////////////////////////////////
// LMH6401 gain control, Wishbone in, shared SPI bus out
// CHANNELS may not exceed CHANNELS_DEFAULT; spare cs_n pins stay high
// SPI_FREQ must be at most CLK_FREQ / 2
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lmh6401_gain_top #(
  parameter int CHANNELS = daq_cfg_pkg::CHANNELS_DEFAULT,
  parameter int CLK_FREQ = daq_cfg_pkg::CLK_FREQ_DEFAULT,
  parameter int SPI_FREQ = daq_cfg_pkg::SPI_FREQ_DEFAULT
) (
  input  logic                   ps_clk,
  input  logic                   rst,
  input  daq_cfg_pkg::wb_req_t   wb_req,
  output daq_cfg_pkg::wb_rsp_t   wb_rsp,
  output lmh6401_pkg::spi_pins_t spi
);
  import lmh6401_pkg::*;

  // ps_clk cycles per SCK half period
  localparam int SCK_HALF = CLK_FREQ / (2 * SPI_FREQ);

  logic                busy;
  logic                frame_done;
  logic                cmd_valid;
  logic                load;
  logic                shift;
  logic                cs_on;
  logic                sck;
  logic                sdi;
  logic [CHANNELS-1:0] cs_n;
  spi_cmd_t            reg_cmd;
  spi_cmd_t            seq_cmd;

  //////////////////////////////////////////////////////////////////////////
  // register block, sequencer, datapath
  //////////////////////////////////////////////////////////////////////////
  gain_wb_regs gain_wb_regs_i (
    .ps_clk,
    .rst,
    .wb_req,
    .wb_rsp,
    .busy,
    .frame_done,
    .cmd_valid,
    .cmd(reg_cmd)
  );

  spi_frame_seq #(
    .SCK_HALF(SCK_HALF)
  ) spi_frame_seq_i (
    .ps_clk,
    .rst,
    .cmd_valid,
    .cmd_in(reg_cmd),
    .busy,
    .frame_done,
    .load,
    .shift,
    .cs_on,
    .sck,
    .cmd_out(seq_cmd)
  );

  spi_shift_sel #(
    .CHANNELS(CHANNELS)
  ) spi_shift_sel_i (
    .ps_clk,
    .rst,
    .load,
    .shift,
    .cs_on,
    .cmd(seq_cmd),
    .pins_cs_n(cs_n),
    .sdi
  );

  // pin bundle, unused selects parked high
  always_comb begin
    spi.cs_n = '1;
    for (int i = 0; i < CHANNELS; i++) begin
      spi.cs_n[i] = cs_n[i];
    end
    spi.sck = sck;
    spi.sdi = sdi;
  end

endmodule

// ==== hw/spi_shift_sel.sv ====
////////////////////////////////////////////////////////////////////////////
// MSB-first shift register and one-hot active-low chip select
// channel indices at or above CHANNELS select no device
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_shift_sel #(
  parameter int CHANNELS = daq_cfg_pkg::CHANNELS_DEFAULT
) (
  input  logic                  ps_clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic                  shift,
  input  logic                  cs_on,
  input  lmh6401_pkg::spi_cmd_t cmd,
  output logic [CHANNELS-1:0]   pins_cs_n,
  output logic                  sdi
);
  import daq_cfg_pkg::*;
  import lmh6401_pkg::*;

  logic [LMH_WORD_W-1:0]  shreg;
  logic [CH_BITS_MAX-1:0] ch_q;

  // sdi low after reset, holds the last bit between frames
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      shreg <= '0;
    end else if (load) begin
      shreg <= cmd.word.raw;
    end else if (shift) begin
      shreg <= {shreg[LMH_WORD_W-2:0], 1'b0};
    end
  end

  // channel held for the whole frame
  always_ff @(posedge ps_clk) begin
    if (load) begin
      ch_q <= cmd.ch;
    end
  end

  assign sdi = shreg[LMH_WORD_W-1];

  // one-hot select, gated by the frame window
  always_comb begin
    pins_cs_n = '1;
    for (int i = 0; i < CHANNELS; i++) begin
      if (cs_on && (ch_q == CH_BITS_MAX'(i))) begin
        pins_cs_n[i] = 1'b0;
      end
    end
  end

endmodule

// ==== hw/spi_frame_seq.sv ====
////////////////////////////////////////////////////////////////////////////
// frame sequencer for one 16-bit LMH6401 write
// SCK_HALF is ps_clk cycles per SCK half period, at least 1
// frame is 33 * SCK_HALF + 1 cycles from cmd_valid to frame_done
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_frame_seq #(
  parameter int SCK_HALF = 50
) (
  input  logic                  ps_clk,
  input  logic                  rst,
  input  logic                  cmd_valid,
  input  lmh6401_pkg::spi_cmd_t cmd_in,
  output logic                  busy,
  output logic                  frame_done,
  output logic                  load,
  output logic                  shift,
  output logic                  cs_on,
  output logic                  sck,
  output lmh6401_pkg::spi_cmd_t cmd_out
);
  import lmh6401_pkg::*;

  localparam int HC_W = $clog2(SCK_HALF + 1);
  localparam logic [HC_W-1:0] HC_LAST = HC_W'(SCK_HALF - 1);
  localparam int BC_W = $clog2(LMH_WORD_W);
  localparam logic [BC_W-1:0] BIT_LAST = BC_W'(LMH_WORD_W - 1);

  typedef enum logic [1:0] {IDLE, LEAD, CLOCK, TRAIL} state_t;

  state_t          state;
  logic [HC_W-1:0] hcnt;
  logic [BC_W-1:0] bcnt;
  logic            half_end;

  assign half_end = hcnt == HC_LAST;

  assign busy = state != IDLE;
  assign cs_on = state != IDLE;
  // datapath latches the command on the same edge we leave idle
  assign load = (state == IDLE) && cmd_valid;
  assign cmd_out = cmd_in;
  // advance sdi with each falling edge, none after the last bit
  assign shift = (state == CLOCK) && half_end && sck && (bcnt != BIT_LAST);

  always_ff @(posedge ps_clk) begin
    if (rst) begin
      state <= IDLE;
      hcnt <= '0;
      bcnt <= '0;
      sck <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      hcnt <= half_end ? '0 : hcnt + 1'b1;
      case (state)
        IDLE: begin
          hcnt <= '0;
          if (cmd_valid) begin
            state <= LEAD;
          end
        end
        // cs low, bit 15 settling before the first rising edge
        LEAD: begin
          if (half_end) begin
            state <= CLOCK;
            sck <= 1'b1;
            bcnt <= '0;
          end
        end
        CLOCK: begin
          if (half_end) begin
            if (sck) begin
              sck <= 1'b0;
              if (bcnt == BIT_LAST) begin
                state <= TRAIL;
              end
            end else begin
              sck <= 1'b1;
              bcnt <= bcnt + 1'b1;
            end
          end
        end
        // hold cs for one half period after the last falling edge
        TRAIL: begin
          if (half_end) begin
            state <= IDLE;
            frame_done <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== hw/gain_wb_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Wishbone classic slave for the gain command and status registers
// CMD writes stall (ack held low) while a frame is on the bus
// read commands are refused since the bus has no SDO line
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gain_wb_regs (
  input  logic                  ps_clk,
  input  logic                  rst,
  input  daq_cfg_pkg::wb_req_t  wb_req,
  output daq_cfg_pkg::wb_rsp_t  wb_rsp,
  input  logic                  busy,
  input  logic                  frame_done,
  output logic                  cmd_valid,
  output lmh6401_pkg::spi_cmd_t cmd
);
  import daq_cfg_pkg::*;
  import lmh6401_pkg::*;

  logic                 ack_q;
  logic [WB_DATA_W-1:0] rd_q;
  logic                 pending;
  logic                 sel_cmd;
  logic                 sel_status;
  logic                 cmd_wr;
  logic                 cmd_refuse;
  logic                 cmd_accept;
  logic                 clr_refused;
  spi_cmd_t             wr_cmd;
  logic                 refused;
  logic [15:0]          frame_cnt;
  logic [WB_DATA_W-1:0] status_word;

  //////////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////////
  // no new cycle counted while the current one is being acked
  assign pending = wb_req.cyc && wb_req.stb && !ack_q;
  assign sel_cmd = wb_req.adr == REG_CMD;
  assign sel_status = wb_req.adr == REG_STATUS;

  // channel and word in the low bits of the data bus
  assign wr_cmd = wb_req.dat_w[$bits(spi_cmd_t)-1:0];

  assign cmd_wr = pending && wb_req.we && sel_cmd;
  // rw set means a device read
  assign cmd_refuse = cmd_wr && wr_cmd.word.f.rw;
  assign cmd_accept = cmd_wr && !wr_cmd.word.f.rw && !busy;
  assign clr_refused = pending && wb_req.we && sel_status && wb_req.dat_w[1];

  // busy also covers the cycle the command is handed over
  assign status_word = {frame_cnt, {(WB_DATA_W - 18){1'b0}}, refused, busy || cmd_valid};

  //////////////////////////////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      cmd_valid <= 1'b0;
      refused <= 1'b0;
      frame_cnt <= '0;
    end else begin
      // CMD writes wait for the sequencer, everything else acks next cycle
      ack_q <= cmd_wr ? (cmd_refuse || cmd_accept) : pending;
      cmd_valid <= cmd_accept;
      if (cmd_refuse) begin
        refused <= 1'b1;
      end else if (clr_refused) begin
        refused <= 1'b0;
      end
      // wraps at 16 bits
      if (frame_done) begin
        frame_cnt <= frame_cnt + 16'd1;
      end
    end
  end

  // payload
  always_ff @(posedge ps_clk) begin
    if (cmd_accept) begin
      cmd <= wr_cmd;
    end
    if (pending) begin
      rd_q <= (sel_status && !wb_req.we) ? status_word : '0;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat_r = rd_q;

endmodule

// ==== hw/lmh6401_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// LMH6401 SPI command format
// word is rw, 7-bit register address, 8-bit data, sent MSB first
// the channel index sits above the word in spi_cmd_t
////////////////////////////////////////////////////////////////////////////
package lmh6401_pkg;

  localparam int LMH_WORD_W = 16;

  // field view of one device word
  typedef struct packed {
    logic       rw;
    logic [6:0] reg_addr;
    logic [7:0] reg_data;
  } lmh6401_fields_t;

  // same 16 bits, either shifted out raw or decoded by field
  typedef union packed {
    logic [LMH_WORD_W-1:0] raw;
    lmh6401_fields_t       f;
  } lmh6401_word_u;

  // command as written by the host
  typedef struct packed {
    logic [daq_cfg_pkg::CH_BITS_MAX-1:0] ch;
    lmh6401_word_u                       word;
  } spi_cmd_t;

  // shared bus pins, one chip select per amplifier
  typedef struct packed {
    logic [daq_cfg_pkg::CHANNELS_DEFAULT-1:0] cs_n;
    logic                                     sck;
    logic                                     sdi;
  } spi_pins_t;

endpackage

// ==== hw/daq_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// board-level settings for the LMH6401 gain path
// register offsets are byte addresses on a 4-bit Wishbone address
// CHANNELS_DEFAULT also sets the width of the chip-select pins
////////////////////////////////////////////////////////////////////////////
package daq_cfg_pkg;

  // amplifier channels and their index width
  localparam int CHANNELS_DEFAULT = 8;
  localparam int CH_BITS_MAX = $clog2(CHANNELS_DEFAULT);

  // Wishbone bus widths
  localparam int WB_DATA_W = 32;
  localparam int WB_ADDR_W = 4;

  // clock defaults, Hz
  localparam int CLK_FREQ_DEFAULT = 100_000_000;
  localparam int SPI_FREQ_DEFAULT = 1_000_000;

  // register map
  localparam logic [WB_ADDR_W-1:0] REG_CMD = 4'h0;
  localparam logic [WB_ADDR_W-1:0] REG_STATUS = 4'h4;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [WB_DATA_W-1:0] dat_r;
  } wb_rsp_t;

endpackage
